/* dv/ex_stage_assert.sv */
`timescale 1ns/100ps

`include "ex_defines.svh"

module ex_stage_assert
(
   input  logic  clk,
   input  logic  reset,
   input  logic  cmt_stall,
   input  logic  flush,
   input  logic  commit_rf_we [`EX_LANES]
);

   genvar i;

   // No register write while the commit side holds
   generate
      for (i = 0; i < `EX_LANES; i++)
      begin : g_hold
         a_no_commit_in_hold : assert property (
            @(posedge clk) disable iff (reset) cmt_stall |-> !commit_rf_we[i])
         else
            $error("commit write enable high during hold on lane %0d", i);
      end
   endgenerate

   // Flush starts clean out of reset
   a_flush_after_reset : assert property (
      @(posedge clk) $fell(reset) |-> !flush)
   else
      $error("flush high in the first cycle after reset");

   // Single cycle pulse
   a_flush_pulse : assert property (
      @(posedge clk) disable iff (reset) flush |=> !flush)
   else
      $error("flush high for two cycles in a row");

endmodule

/* dv/ex_stage_tb.sv */
`timescale 1ns/100ps

`include "ex_defines.svh"

module ex_stage_tb
   import ex_pkg::*;
();

   localparam int MAX_REC = 64;             // Issue records the trace may hold
   localparam int NFLD    = 11;             // Fields per lane in an issue record

   logic                   clk;
   logic                   reset;
   logic                   cmt_stall;
   logic                   ex_valid        [`EX_LANES];
   alu_op_t                ex_alu_opc      [`EX_LANES];
   bru_op_t                ex_bru_opc      [`EX_LANES];
   logic [`EX_PC_W-1:0]    ex_pc           [`EX_LANES];
   logic [`EX_DW-1:0]      ex_imm          [`EX_LANES];
   logic [`EX_DW-1:0]      ex_operand1     [`EX_LANES];
   logic [`EX_DW-1:0]      ex_operand2     [`EX_LANES];
   logic [`EX_REG_AW-1:0]  ex_rf_waddr     [`EX_LANES];
   logic                   ex_rf_we        [`EX_LANES];
   logic                   ex_pred_taken   [`EX_LANES];
   logic [`EX_PC_W-1:0]    ex_pred_tgt     [`EX_LANES];
   logic                   flush;
   logic [`EX_PC_W-1:0]    flush_tgt;
   logic [`EX_DW-1:0]      ro_s1_rf_dout   [`EX_LANES];
   logic                   ro_s1_rf_we     [`EX_LANES];
   logic [`EX_REG_AW-1:0]  ro_s1_rf_waddr  [`EX_LANES];
   logic [`EX_DW-1:0]      commit_rf_wdat  [`EX_LANES];
   logic                   commit_rf_we    [`EX_LANES];
   logic [`EX_REG_AW-1:0]  commit_rf_waddr [`EX_LANES];

   logic [31:0]            rec_f [MAX_REC][`EX_LANES][NFLD];  // Raw issue fields
   int                     n_rec;
   logic [37:0]            exp_cmt_q [$];   // {lane, addr, data} in commit order
   logic [`EX_PC_W-1:0]    exp_flush_q [$];
   logic [15:0]            lfsr;
   int                     cycle_cnt;
   int                     cycle_limit;
   logic                   limit_set;
   int                     err_cmt;         // Commit stream mismatches
   int                     err_flush;
   int                     err_byp;         // s1 to commit timing
   int                     err_stall;
   int                     err_trace;
   logic                   snap_we   [`EX_LANES];   // ro_s1 as seen in last open cycle
   logic [`EX_REG_AW-1:0]  snap_addr [`EX_LANES];
   logic [`EX_DW-1:0]      snap_dat  [`EX_LANES];

   ex_stage ex_stage_inst (.*);

   bind ex_stage ex_stage_assert ex_stage_assert_inst (
      .clk          (clk),
      .reset        (reset),
      .cmt_stall    (cmt_stall),
      .flush        (flush),
      .commit_rf_we (commit_rf_we)
   );

   // Galois form, taps 16 14 13 11
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      lfsr_next = s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
   endfunction

   task automatic drive_idle();
      for (int l = 0; l < `EX_LANES; l++)
      begin
         ex_valid[l]      <= 1'b0;
         ex_alu_opc[l]    <= ALU_NONE;
         ex_bru_opc[l]    <= BRU_NONE;
         ex_pc[l]         <= '0;
         ex_imm[l]        <= '0;
         ex_operand1[l]   <= '0;
         ex_operand2[l]   <= '0;
         ex_rf_waddr[l]   <= '0;
         ex_rf_we[l]      <= 1'b0;
         ex_pred_taken[l] <= 1'b0;
         ex_pred_tgt[l]   <= '0;
      end
   endtask

   task automatic present_group(input int k);
      for (int l = 0; l < `EX_LANES; l++)
      begin
         ex_valid[l]      <= rec_f[k][l][0][0];
         ex_alu_opc[l]    <= alu_op_t'(rec_f[k][l][1][3:0]);
         ex_bru_opc[l]    <= bru_op_t'(rec_f[k][l][2][2:0]);
         ex_pc[l]         <= rec_f[k][l][3][`EX_PC_W-1:0];
         ex_imm[l]        <= rec_f[k][l][4];
         ex_operand1[l]   <= rec_f[k][l][5];
         ex_operand2[l]   <= rec_f[k][l][6];
         ex_rf_waddr[l]   <= rec_f[k][l][7][`EX_REG_AW-1:0];
         ex_rf_we[l]      <= rec_f[k][l][8][0];
         ex_pred_taken[l] <= rec_f[k][l][9][0];
         ex_pred_tgt[l]   <= rec_f[k][l][10][`EX_PC_W-1:0];
      end
   endtask

   task automatic load_trace();
      int          fd;
      int          code;
      logic [31:0] tag;
      logic [1023:0] line;
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] c;
      fd = $fopen("dv/ex_stage_trace.txt", "r");
      if (fd == 0)
      begin
         $display("Cannot open the trace file dv/ex_stage_trace.txt");
         err_trace++;
         return;
      end
      while (!$feof(fd))
      begin
         code = $fscanf(fd, "%s", tag);
         if (code != 1)
            break;
         if (tag == "#")
            code = $fgets(line, fd);                 // Column notes
         else if (tag == "I" && n_rec < MAX_REC)
         begin
            for (int l = 0; l < `EX_LANES; l++)
               code = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h",
                              rec_f[n_rec][l][0], rec_f[n_rec][l][1], rec_f[n_rec][l][2],
                              rec_f[n_rec][l][3], rec_f[n_rec][l][4], rec_f[n_rec][l][5],
                              rec_f[n_rec][l][6], rec_f[n_rec][l][7], rec_f[n_rec][l][8],
                              rec_f[n_rec][l][9], rec_f[n_rec][l][10]);
            n_rec++;
         end
         else if (tag == "E")
         begin
            code = $fscanf(fd, "%h %h %h", a, b, c);
            exp_cmt_q.push_back({a[0], b[`EX_REG_AW-1:0], c});
         end
         else if (tag == "F")
         begin
            code = $fscanf(fd, "%h", a);
            exp_flush_q.push_back(a[`EX_PC_W-1:0]);
         end
         else
         begin
            $display("Unknown record type in the trace file");
            err_trace++;
         end
      end
      $fclose(fd);
   endtask

   initial
   begin
      clk = 1'b0;
      forever #2 clk = ~clk;                    // 4 ns period
   end

   // Watchdog
   initial
   begin
      cycle_cnt = 0;
      wait (limit_set);
      while (cycle_cnt < cycle_limit)
      begin
         @(posedge clk);
         cycle_cnt++;
      end
      $display("Run timed out after %0d cycles", cycle_cnt);
      $display("Errors found");
      $finish;
   end

   // Output checks, sampled mid cycle where everything is settled
   always @(negedge clk)
   begin
      logic [37:0] got;
      if (reset)
      begin
         for (int l = 0; l < `EX_LANES; l++)
            snap_we[l] = 1'b0;
      end
      else if (cmt_stall)
      begin
         for (int l = 0; l < `EX_LANES; l++)
            assert (!commit_rf_we[l])
            else
            begin
               err_stall++;
               $display("[FAIL] %0t commit write on lane %0d during hold", $time, l);
            end
      end
      else
      begin
         for (int l = 0; l < `EX_LANES; l++)
         begin
            assert (commit_rf_we[l] == snap_we[l] &&
                    (!snap_we[l] || (commit_rf_waddr[l] == snap_addr[l] &&
                                     commit_rf_wdat[l] == snap_dat[l])))
            else
            begin
               err_byp++;
               $display("[FAIL] %0t lane %0d commit does not follow its s1 entry", $time, l);
            end
            if (commit_rf_we[l])
            begin
               got = {l[0], commit_rf_waddr[l], commit_rf_wdat[l]};
               if (exp_cmt_q.size() == 0)
               begin
                  err_cmt++;
                  $display("Commit write on lane %0d at %0t with none expected", l, $time);
               end
               else
               begin
                  assert (got == exp_cmt_q[0])
                  else
                  begin
                     err_cmt++;
                     $display("[FAIL] %0t commit expected %h got %h", $time,
                              exp_cmt_q[0], got);
                  end
                  void'(exp_cmt_q.pop_front());
               end
            end
            snap_we[l]   = ro_s1_rf_we[l];
            snap_addr[l] = ro_s1_rf_waddr[l];
            snap_dat[l]  = ro_s1_rf_dout[l];
         end
      end
      if (!reset && flush)
      begin
         if (exp_flush_q.size() == 0)
         begin
            err_flush++;
            $display("Flush raised at %0t with none expected", $time);
         end
         else
         begin
            assert (flush_tgt == exp_flush_q[0])
            else
            begin
               err_flush++;
               $display("[FAIL] %0t flush target expected %h got %h", $time,
                        exp_flush_q[0], flush_tgt);
            end
            void'(exp_flush_q.pop_front());
         end
      end
   end

   initial
   begin
      logic hold;
      logic b0;
      logic b1;
      int   errs;
      reset     = 1'b1;
      cmt_stall = 1'b0;
      limit_set = 1'b0;
      n_rec     = 0;
      err_cmt   = 0;
      err_flush = 0;
      err_byp   = 0;
      err_stall = 0;
      err_trace = 0;
      lfsr      = 16'd31716;
      drive_idle();
      load_trace();
      cycle_limit = 4 * n_rec + 100;
      limit_set   = 1'b1;
      repeat (10) @(posedge clk);
      reset <= 1'b0;
      for (int k = 0; k < n_rec; k++)
      begin
         b0   = lfsr[0];
         lfsr = lfsr_next(lfsr);
         b1   = lfsr[0];
         lfsr = lfsr_next(lfsr);
         hold = b0 & b1;
         present_group(k);
         if (hold)
         begin
            cmt_stall <= 1'b1;                  // Record waits through the hold
            @(posedge clk);
         end
         cmt_stall <= 1'b0;
         @(posedge clk);
      end
      drive_idle();
      while (exp_cmt_q.size() != 0 || exp_flush_q.size() != 0)
         @(posedge clk);
      repeat (4) @(posedge clk);                 // Catch any trailing extra write
      errs = err_cmt + err_flush + err_byp + err_stall + err_trace;
      $display("Error count %0d: commit %0d flush %0d bypass %0d stall %0d trace %0d",
               errs, err_cmt, err_flush, err_byp, err_stall, err_trace);
      if (errs == 0)
         $display("No errors");
      else
         $display("Errors found");
      $finish;
   end

endmodule

/* dv/ex_stage_trace.txt */
# I: valid alu bru pc imm op1 op2 waddr we pred_taken pred_tgt, lane 0 line then lane 1
# E: lane waddr wdata in commit order, F: flush target in order
I 1 1 0 40 0 5 7 01 1 0 0
  1 2 0 41 0 10 3 02 1 0 0
I 1 3 0 42 0 f0f0 ff00 03 1 0 0
  1 4 0 43 0 f0f0 0f0f 04 1 0 0
I 1 5 0 44 0 ffffffff 0000ffff 05 1 0 0
  1 6 0 45 0 1 24 06 1 0 0
I 1 7 0 46 0 80000000 1f 07 1 0 0
  1 8 0 47 0 ffffffff 1 08 1 0 0
I 1 9 0 48 12345000 0 0 09 1 0 0
  1 0 0 49 0 3 4 0a 1 0 0
I 1 0 1 4a 10 5 5 00 0 1 5a
  1 0 5 4b 20 0 0 0b 1 1 6b
I 1 0 4 4c 0 5 3 00 0 0 0
  1 0 3 4d 8 ffffffff 1 00 0 1 55
I 1 0 2 4e 10 1 2 0c 1 0 0
  1 1 0 4f 0 1 1 0d 1 0 0
I 1 1 0 50 0 3 3 0e 1 0 0
  1 1 0 51 0 3 3 0f 1 0 0
I 1 1 0 60 0 100 23 10 1 0 0
  1 0 1 61 4 4 4 11 1 0 0
I 1 1 0 62 0 9 9 12 1 0 0
  1 1 0 63 0 9 9 13 1 0 0
I 1 0 6 65 0 80 0 00 0 1 70
  1 0 5 66 2 0 0 14 1 0 0
I 1 1 0 70 0 2 2 1e 1 0 0
  1 1 0 71 0 2 2 1f 1 0 0
I 1 1 0 80 0 7fffffff 1 15 1 0 0
  0 1 0 81 0 1 1 16 1 0 0
I 1 2 0 82 0 0 1 17 1 0 0
  1 5 0 83 0 a5a5a5a5 ffffffff 18 1 0 0
E 0 01 0000000c
E 1 02 0000000d
E 0 03 0000f000
E 1 04 0000ffff
E 0 05 ffff0000
E 1 06 00000010
E 0 07 00000001
E 1 08 00000001
E 0 09 12345000
E 1 0a 00000000
E 1 0b 0000004c
E 0 0c 0000004f
E 0 10 00000123
E 1 11 00000062
E 0 15 80000000
E 0 17 ffffffff
E 1 18 5a5a5a5a
F 5e
F 65
F 80

/* hdl/ex_alu.sv */
`timescale 1ns/100ps

`include "ex_defines.svh"

module ex_alu
   import ex_pkg::*;
(
   input  alu_op_t              opc,
   input  logic [`EX_DW-1:0]    operand1,
   input  logic [`EX_DW-1:0]    operand2,
   input  logic [`EX_DW-1:0]    imm,
   output logic [`EX_DW-1:0]    result
);

   logic [4:0]             shamt;     // Low bits of operand 2
   logic                   lt_signed; // Operand 1 below operand 2

   assign shamt     = operand2[4:0];
   assign lt_signed = ($signed(operand1) < $signed(operand2));

   always_comb
   begin
      case (opc)
         ALU_ADD:
            result = operand1 + operand2;
         ALU_SUB:
            result = operand1 - operand2;
         ALU_AND:
            result = operand1 & operand2;
         ALU_OR:
            result = operand1 | operand2;
         ALU_XOR:
            result = operand1 ^ operand2;
         ALU_SLL:
            result = operand1 << shamt;       // Logical left
         ALU_SRL:
            result = operand1 >> shamt;       // Logical right, zero fill
         ALU_SLT:
            result = {{(`EX_DW-1){1'b0}}, lt_signed};
         ALU_LUI:
            result = imm;                     // Upper immediate already placed
         default:
            result = '0;                      // ALU_NONE and unused codes
      endcase
   end

endmodule

/* hdl/ex_bru.sv */
`timescale 1ns/100ps

`include "ex_defines.svh"

module ex_bru
   import ex_pkg::*;
(
   input  logic                   valid,
   input  bru_op_t                opc,
   input  logic [`EX_PC_W-1:0]    pc,
   input  logic [`EX_DW-1:0]      imm,
   input  logic [`EX_DW-1:0]      operand1,
   input  logic [`EX_DW-1:0]      operand2,
   input  logic                   pred_taken,
   input  logic [`EX_PC_W-1:0]    pred_tgt,
   output logic [`EX_DW-1:0]      link,
   output logic                   se_fail,
   output logic [`EX_PC_W-1:0]    se_tgt
);

   logic [`EX_PC_W-1:0]    pc_p1;      // Fall through address
   logic [`EX_PC_W-1:0]    tgt;        // Branch or jump target
   logic [`EX_PC_W-1:0]    npc_act;    // Resolved next PC
   logic [`EX_PC_W-1:0]    npc_pred;   // Next PC the frontend fetched
   logic                   taken;
   logic                   is_br;

   assign pc_p1 = pc + `EX_PC_W'(1);

   always_comb
   begin
      case (opc)
         BRU_BEQ:
            taken = (operand1 == operand2);
         BRU_BNE:
            taken = (operand1 != operand2);
         BRU_BLT:
            taken = ($signed(operand1) < $signed(operand2));
         BRU_BLTU:
            taken = (operand1 < operand2);
         BRU_JREL,
         BRU_JREG:
            taken = 1'b1;                     // Unconditional
         default:
            taken = 1'b0;
      endcase
   end

   assign tgt = (opc == BRU_JREG) ? operand1[`EX_PC_W-1:0]
                                  : pc + imm[`EX_PC_W-1:0];   // Relative offset in words

   assign npc_act  = taken ? tgt : pc_p1;
   assign npc_pred = pred_taken ? pred_tgt : pc_p1;
   assign is_br    = (opc != BRU_NONE);

   // Speculation check against the frontend prediction
   assign se_fail = valid & is_br & (npc_act != npc_pred);
   assign se_tgt  = npc_act;

   assign link = {{(`EX_DW-`EX_PC_W){1'b0}}, pc_p1};   // Return address

endmodule

/* hdl/ex_defines.svh */
`ifndef EX_DEFINES_SVH
`define EX_DEFINES_SVH

// Issue width of the execute stage
`define EX_LANES  2       // Lane 0 gates commit of the younger lanes

// Datapath widths
`define EX_DW     32      // Integer data
`define EX_PC_W   30      // Word address, one step per instruction
`define EX_REG_AW 5       // Register file address

`endif

/* hdl/ex_lane.sv */
`timescale 1ns/100ps

`include "ex_defines.svh"

module ex_lane
   import ex_pkg::*;
(
   input  logic                   clk,
   input  logic                   reset,
   input  logic                   p_ce,          // Pipeline advance
   input  logic                   flush_s1,      // Kill the group entering s1
   input  logic                   ex_valid,
   input  logic                   cmt_valid,     // Allowed to commit by older lanes
   input  alu_op_t                ex_alu_opc,
   input  bru_op_t                ex_bru_opc,
   input  logic [`EX_PC_W-1:0]    ex_pc,
   input  logic [`EX_DW-1:0]      ex_imm,
   input  logic [`EX_DW-1:0]      ex_operand1,
   input  logic [`EX_DW-1:0]      ex_operand2,
   input  logic [`EX_REG_AW-1:0]  ex_rf_waddr,
   input  logic                   ex_rf_we,
   input  logic                   ex_pred_taken,
   input  logic [`EX_PC_W-1:0]    ex_pred_tgt,
   output logic                   se_fail,
   output logic [`EX_PC_W-1:0]    se_tgt,
   output logic [`EX_DW-1:0]      ro_s1_rf_dout,
   output logic                   ro_s1_rf_we,
   output logic [`EX_REG_AW-1:0]  ro_s1_rf_waddr,
   output logic [`EX_DW-1:0]      commit_rf_wdat,
   output logic [`EX_REG_AW-1:0]  commit_rf_waddr,
   output logic                   commit_rf_we
);

   logic [`EX_DW-1:0]      alu_result;
   logic [`EX_DW-1:0]      link;          // PC plus one from the branch unit
   logic [`EX_DW-1:0]      s1i_rf_dout;   // Selected lane result
   logic                   s1i_rf_we;
   logic                   is_br;
   logic                   cmt_we_r;      // Commit stage enable before hold gating

   ex_alu u_alu (
      .opc      (ex_alu_opc),
      .operand1 (ex_operand1),
      .operand2 (ex_operand2),
      .imm      (ex_imm),
      .result   (alu_result)
   );

   ex_bru u_bru (
      .valid      (ex_valid),
      .opc        (ex_bru_opc),
      .pc         (ex_pc),
      .imm        (ex_imm),
      .operand1   (ex_operand1),
      .operand2   (ex_operand2),
      .pred_taken (ex_pred_taken),
      .pred_tgt   (ex_pred_tgt),
      .link       (link),
      .se_fail    (se_fail),
      .se_tgt     (se_tgt)
   );

   assign is_br       = (ex_bru_opc != BRU_NONE);
   assign s1i_rf_dout = (is_br & ex_rf_we) ? link : alu_result;   // Link write for calls
   assign s1i_rf_we   = cmt_valid & ex_rf_we & ~flush_s1;

   // Stage 1, also the first bypass point
   always_ff @(posedge clk)
   begin
      if (reset)
         ro_s1_rf_we <= 1'b0;
      else if (p_ce)
         ro_s1_rf_we <= s1i_rf_we;
   end

   always_ff @(posedge clk)
   begin
      if (p_ce)
      begin
         ro_s1_rf_dout  <= s1i_rf_dout;
         ro_s1_rf_waddr <= ex_rf_waddr;
      end
   end

   // Commit stage
   always_ff @(posedge clk)
   begin
      if (reset)
         cmt_we_r <= 1'b0;
      else if (p_ce)
         cmt_we_r <= ro_s1_rf_we;
   end

   always_ff @(posedge clk)
   begin
      if (p_ce)
      begin
         commit_rf_wdat  <= ro_s1_rf_dout;
         commit_rf_waddr <= ro_s1_rf_waddr;
      end
   end

   assign commit_rf_we = cmt_we_r & p_ce;   // Held stage writes only once

endmodule

/* hdl/ex_pkg.sv */
package ex_pkg;

   // ALU operations, one per lane
   typedef enum logic [3:0] {
      ALU_NONE = 4'd0,     // Result forced to zero
      ALU_ADD  = 4'd1,
      ALU_SUB  = 4'd2,
      ALU_AND  = 4'd3,
      ALU_OR   = 4'd4,
      ALU_XOR  = 4'd5,
      ALU_SLL  = 4'd6,     // Shift amount from operand 2
      ALU_SRL  = 4'd7,
      ALU_SLT  = 4'd8,     // Signed compare
      ALU_LUI  = 4'd9      // Passes the immediate
   } alu_op_t;

   // Branch operations
   typedef enum logic [2:0] {
      BRU_NONE = 3'd0,     // Not a branch
      BRU_BEQ  = 3'd1,
      BRU_BNE  = 3'd2,
      BRU_BLT  = 3'd3,     // Signed
      BRU_BLTU = 3'd4,
      BRU_JREL = 3'd5,     // PC relative jump
      BRU_JREG = 3'd6      // Jump to operand 1
   } bru_op_t;

endpackage

/* hdl/ex_stage.sv */
`timescale 1ns/100ps

`include "ex_defines.svh"

module ex_stage
   import ex_pkg::*;
(
   input  logic                   clk,
   input  logic                   reset,
   input  logic                   cmt_stall,                         // Hold from commit side
   input  logic                   ex_valid        [`EX_LANES],
   input  alu_op_t                ex_alu_opc      [`EX_LANES],
   input  bru_op_t                ex_bru_opc      [`EX_LANES],
   input  logic [`EX_PC_W-1:0]    ex_pc           [`EX_LANES],
   input  logic [`EX_DW-1:0]      ex_imm          [`EX_LANES],
   input  logic [`EX_DW-1:0]      ex_operand1     [`EX_LANES],
   input  logic [`EX_DW-1:0]      ex_operand2     [`EX_LANES],
   input  logic [`EX_REG_AW-1:0]  ex_rf_waddr     [`EX_LANES],
   input  logic                   ex_rf_we        [`EX_LANES],
   input  logic                   ex_pred_taken   [`EX_LANES],
   input  logic [`EX_PC_W-1:0]    ex_pred_tgt     [`EX_LANES],
   output logic                   flush,
   output logic [`EX_PC_W-1:0]    flush_tgt,
   output logic [`EX_DW-1:0]      ro_s1_rf_dout   [`EX_LANES],
   output logic                   ro_s1_rf_we     [`EX_LANES],
   output logic [`EX_REG_AW-1:0]  ro_s1_rf_waddr  [`EX_LANES],
   output logic [`EX_DW-1:0]      commit_rf_wdat  [`EX_LANES],
   output logic                   commit_rf_we    [`EX_LANES],
   output logic [`EX_REG_AW-1:0]  commit_rf_waddr [`EX_LANES]
);

   logic                   p_ce;                       // All stages advance
   logic                   flush_s1;                   // Kill for the issuing group
   logic [`EX_LANES-1:0]   se_fail;                    // Per lane misprediction
   logic [`EX_PC_W-1:0]    se_tgt [`EX_LANES];         // Per lane resolved next PC
   logic [`EX_LANES-1:0]   cmt_mask;                   // No older lane failed
   logic                   cmt_valid [`EX_LANES];
   logic                   se_fail_any;
   logic [`EX_PC_W-1:0]    se_tgt_sel;                 // Target of the oldest failing lane
   logic                   se_flush_r;                 // Pending flush request

   genvar i;

   assign p_ce     = ~cmt_stall;
   assign flush_s1 = flush;

   // Younger lanes are squashed behind a failing branch
   always_comb
   begin
      cmt_mask[0] = 1'b1;
      for (int j = 1; j < `EX_LANES; j++)
         cmt_mask[j] = cmt_mask[j-1] & ~se_fail[j-1];
   end

   generate
      for (i = 0; i < `EX_LANES; i++)
      begin : g_lane
         assign cmt_valid[i] = ex_valid[i] & cmt_mask[i];

         ex_lane u_lane (
            .clk             (clk),
            .reset           (reset),
            .p_ce            (p_ce),
            .flush_s1        (flush_s1),
            .ex_valid        (ex_valid[i]),
            .cmt_valid       (cmt_valid[i]),
            .ex_alu_opc      (ex_alu_opc[i]),
            .ex_bru_opc      (ex_bru_opc[i]),
            .ex_pc           (ex_pc[i]),
            .ex_imm          (ex_imm[i]),
            .ex_operand1     (ex_operand1[i]),
            .ex_operand2     (ex_operand2[i]),
            .ex_rf_waddr     (ex_rf_waddr[i]),
            .ex_rf_we        (ex_rf_we[i]),
            .ex_pred_taken   (ex_pred_taken[i]),
            .ex_pred_tgt     (ex_pred_tgt[i]),
            .se_fail         (se_fail[i]),
            .se_tgt          (se_tgt[i]),
            .ro_s1_rf_dout   (ro_s1_rf_dout[i]),
            .ro_s1_rf_we     (ro_s1_rf_we[i]),
            .ro_s1_rf_waddr  (ro_s1_rf_waddr[i]),
            .commit_rf_wdat  (commit_rf_wdat[i]),
            .commit_rf_waddr (commit_rf_waddr[i]),
            .commit_rf_we    (commit_rf_we[i])
         );
      end
   endgenerate

   // Scan from the youngest lane so the oldest failing one wins
   always_comb
   begin
      se_fail_any = 1'b0;
      se_tgt_sel  = se_tgt[0];
      for (int j = `EX_LANES-1; j >= 0; j--)
         if (se_fail[j])
         begin
            se_fail_any = 1'b1;
            se_tgt_sel  = se_tgt[j];
         end
   end

   always_ff @(posedge clk)
   begin
      if (reset)
         se_flush_r <= 1'b0;
      else if (p_ce | flush_s1)
         se_flush_r <= se_fail_any & ~flush_s1;   // Group seen during flush is dropped
   end

   always_ff @(posedge clk)
   begin
      if (p_ce)
         flush_tgt <= se_tgt_sel;
   end

   assign flush = se_flush_r & p_ce;   // Pending request waits out the hold

endmodule

/* project.f */
+incdir+hdl
hdl/ex_pkg.sv
hdl/ex_alu.sv
hdl/ex_bru.sv
hdl/ex_lane.sv
hdl/ex_stage.sv
dv/ex_stage_assert.sv
dv/ex_stage_tb.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" &&
rm -f sim.log &&
verilator --binary --timing --assert -Wno-fatal -f project.f \
   --top-module ex_stage_tb -o ex_stage_sim &&
./obj_dir/ex_stage_sim > sim.log 2>&1
grep -q "^No errors$" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
